//--- rv_decode_pkg.sv
// rv64i decoder shared widths, encodings and bundles
package rv_decode_pkg;

  localparam int INST_W       = 32;
  localparam int GPR_ADDR_W   = 5;
  localparam int CSR_ADDR_W   = 12;
  localparam int XLEN_DEFAULT = 64;

  // alu operand b select
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2; // return address pc + 4

  typedef enum logic [5:0] {
    INST_NONE = 6'd0,
    INST_LUI, INST_AUIPC, INST_JAL, INST_JALR,
    INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
    INST_LB, INST_LH, INST_LW, INST_LD, INST_LBU, INST_LHU, INST_LWU,
    INST_SB, INST_SH, INST_SW, INST_SD,
    INST_ADDI, INST_SLTI, INST_SLTIU, INST_XORI, INST_ORI, INST_ANDI,
    INST_SLLI, INST_SRLI, INST_SRAI,
    INST_ADD, INST_SUB, INST_SLL, INST_SLT, INST_SLTU,
    INST_XOR, INST_SRL, INST_SRA, INST_OR, INST_AND,
    INST_ADDIW, INST_SLLIW, INST_SRLIW, INST_SRAIW,
    INST_ADDW, INST_SUBW, INST_SLLW, INST_SRLW, INST_SRAW,
    INST_CSRRW, INST_CSRRS, INST_CSRRWI,
    INST_ECALL, INST_EBREAK, INST_MRET
  } inst_e;

  typedef enum logic [2:0] {
    FMT_R    = 3'd7,
    FMT_I    = 3'd0,
    FMT_U    = 3'd1,
    FMT_S    = 3'd2,
    FMT_B    = 3'd3,
    FMT_J    = 3'd4,
    FMT_NONE = 3'd6
  } fmt_e;

  typedef enum logic [4:0] {
    ALU_ADD     = 5'd0,
    ALU_SUB     = 5'd1,
    ALU_SLT     = 5'd2,
    ALU_SLTU    = 5'd3,
    ALU_XOR     = 5'd4,
    ALU_AND     = 5'd5,
    ALU_OR      = 5'd6,
    ALU_SLL     = 5'd7,
    ALU_SRL     = 5'd8,
    ALU_SRA     = 5'd9,
    ALU_COPYIMM = 5'd15,
    ALU_INVALID = 5'd31
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_JAL, BR_JALR, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
  } br_func_e;

  typedef enum logic [2:0] {
    MEM_SB, MEM_UB, MEM_SH, MEM_UH, MEM_SW, MEM_UW, MEM_D, MEM_NONE
  } mem_op_e;

  typedef struct packed {
    inst_e kind;
    fmt_e  fmt;
  } match_t;

  // field order i, u, s, b, j, z; each field XLEN_DEFAULT wide
  typedef struct packed {
    logic [XLEN_DEFAULT-1:0] i;
    logic [XLEN_DEFAULT-1:0] u;
    logic [XLEN_DEFAULT-1:0] s;
    logic [XLEN_DEFAULT-1:0] b;
    logic [XLEN_DEFAULT-1:0] j;
    logic [XLEN_DEFAULT-1:0] z;
  } imm_set_t;

  typedef struct packed {
    logic [GPR_ADDR_W-1:0] rs1;
    logic [GPR_ADDR_W-1:0] rs2;
    logic [GPR_ADDR_W-1:0] rd;
    logic [CSR_ADDR_W-1:0] csr;
  } fields_t;

  typedef struct packed {
    logic       br_en;
    br_func_e   br_func;
    logic       alu_src1_pc;
    logic [1:0] alu_src2_sel;
    alu_op_e    alu_op;
    logic       word_cut;  // 32-bit truncation for the w forms
    logic       gpr_wen;
    logic       mem_ren;
    logic       mem_wen;
    mem_op_e    mem_op;
    logic       csr_inst;  // csr data goes back to the gpr
    logic       csr_ren;
    logic       csr_wen;
    logic [2:0] csr_op;
  } ctrl_t;

  typedef struct packed {
    logic ecall;
    logic ebreak;
    logic mret;
    logic invalid;
  } exc_t;

endpackage

//--- rv_inst_match.sv
// instruction matcher, finds the kind and encoding format of a raw word
`timescale 1ns/100ps

module rv_inst_match
  import rv_decode_pkg::*;
(
  input  logic [INST_W-1:0] i_inst,
  output match_t            o_match
);

  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  localparam logic [INST_W-1:0] MRET_WORD = 32'h3020_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  inst_e      kind;
  fmt_e       fmt;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    kind = INST_NONE;
    case (opcode_e'(opcode))
      OPC_LUI:   kind = INST_LUI;
      OPC_AUIPC: kind = INST_AUIPC;
      OPC_JAL:   kind = INST_JAL;
      OPC_JALR:  if (funct3 == 3'd0) kind = INST_JALR;
      OPC_BRANCH: begin
        case (funct3)
          3'd0: kind = INST_BEQ;
          3'd1: kind = INST_BNE;
          3'd4: kind = INST_BLT;
          3'd5: kind = INST_BGE;
          3'd6: kind = INST_BLTU;
          3'd7: kind = INST_BGEU;
          default: kind = INST_NONE;
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'd0: kind = INST_LB;
          3'd1: kind = INST_LH;
          3'd2: kind = INST_LW;
          3'd3: kind = INST_LD;
          3'd4: kind = INST_LBU;
          3'd5: kind = INST_LHU;
          3'd6: kind = INST_LWU;
          default: kind = INST_NONE;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'd0: kind = INST_SB;
          3'd1: kind = INST_SH;
          3'd2: kind = INST_SW;
          3'd3: kind = INST_SD;
          default: kind = INST_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'd0: kind = INST_ADDI;
          3'd2: kind = INST_SLTI;
          3'd3: kind = INST_SLTIU;
          3'd4: kind = INST_XORI;
          3'd6: kind = INST_ORI;
          3'd7: kind = INST_ANDI;
          // 6-bit shamt on rv64, funct7[0] belongs to it
          3'd1: if (funct7[6:1] == 6'b000000) kind = INST_SLLI;
          3'd5: begin
            if (funct7[6:1] == 6'b000000) kind = INST_SRLI;
            else if (funct7[6:1] == 6'b010000) kind = INST_SRAI;
          end
          default: kind = INST_NONE;
        endcase
      end
      OPC_OP: begin
        case ({funct7, funct3})
          {7'h00, 3'd0}: kind = INST_ADD;
          {7'h20, 3'd0}: kind = INST_SUB;
          {7'h00, 3'd1}: kind = INST_SLL;
          {7'h00, 3'd2}: kind = INST_SLT;
          {7'h00, 3'd3}: kind = INST_SLTU;
          {7'h00, 3'd4}: kind = INST_XOR;
          {7'h00, 3'd5}: kind = INST_SRL;
          {7'h20, 3'd5}: kind = INST_SRA;
          {7'h00, 3'd6}: kind = INST_OR;
          {7'h00, 3'd7}: kind = INST_AND;
          default:       kind = INST_NONE; // m extension lands here
        endcase
      end
      OPC_OP_IMM_32: begin
        case ({funct7, funct3})
          {7'h00, 3'd1}: kind = INST_SLLIW;
          {7'h00, 3'd5}: kind = INST_SRLIW;
          {7'h20, 3'd5}: kind = INST_SRAIW;
          default:       kind = (funct3 == 3'd0) ? INST_ADDIW : INST_NONE;
        endcase
      end
      OPC_OP_32: begin
        case ({funct7, funct3})
          {7'h00, 3'd0}: kind = INST_ADDW;
          {7'h20, 3'd0}: kind = INST_SUBW;
          {7'h00, 3'd1}: kind = INST_SLLW;
          {7'h00, 3'd5}: kind = INST_SRLW;
          {7'h20, 3'd5}: kind = INST_SRAW;
          default:       kind = INST_NONE;
        endcase
      end
      OPC_SYSTEM: begin
        case (funct3)
          3'd0: begin
            if (i_inst == MRET_WORD) kind = INST_MRET;
            else if (i_inst[31:20] == 12'd0) kind = INST_ECALL;
            else if (i_inst[31:20] == 12'd1) kind = INST_EBREAK;
          end
          3'd1: kind = INST_CSRRW;
          3'd2: kind = INST_CSRRS;
          3'd5: kind = INST_CSRRWI;
          default: kind = INST_NONE;
        endcase
      end
      default: kind = INST_NONE;
    endcase
  end

  always_comb begin
    case (kind)
      INST_LUI, INST_AUIPC:                       fmt = FMT_U;
      INST_JAL:                                   fmt = FMT_J;
      INST_BEQ, INST_BNE, INST_BLT, INST_BGE,
      INST_BLTU, INST_BGEU:                       fmt = FMT_B;
      INST_SB, INST_SH, INST_SW, INST_SD:         fmt = FMT_S;
      INST_ADD, INST_SUB, INST_SLL, INST_SLT, INST_SLTU, INST_XOR,
      INST_SRL, INST_SRA, INST_OR, INST_AND, INST_ADDW, INST_SUBW,
      INST_SLLW, INST_SRLW, INST_SRAW, INST_MRET: fmt = FMT_R;
      INST_NONE:                                  fmt = FMT_NONE;
      default:                                    fmt = FMT_I;
    endcase
  end

  assign o_match = '{kind: kind, fmt: fmt};

endmodule

//--- rv_imm_gen.sv
// immediate generator, builds every immediate form of the raw word
`timescale 1ns/100ps

module rv_imm_gen
  import rv_decode_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic [INST_W-1:0] i_inst,
  output imm_set_t          o_imms
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_z;

  // sign extension to XLEN through signed size casts
  assign imm_i = XLEN'(signed'(i_inst[31:20]));
  assign imm_u = XLEN'(signed'({i_inst[31:12], 12'b0}));
  assign imm_s = XLEN'(signed'({i_inst[31:25], i_inst[11:7]}));
  assign imm_b = XLEN'(signed'({i_inst[31], i_inst[7], i_inst[30:25],
                                i_inst[11:8], 1'b0}));
  assign imm_j = XLEN'(signed'({i_inst[31], i_inst[19:12], i_inst[20],
                                i_inst[30:21], 1'b0}));
  assign imm_z = XLEN'(i_inst[19:15]); // csr uimm, zero extended

  // widen into the fixed-width bundle
  always_comb begin
    o_imms.i = XLEN_DEFAULT'(signed'(imm_i));
    o_imms.u = XLEN_DEFAULT'(signed'(imm_u));
    o_imms.s = XLEN_DEFAULT'(signed'(imm_s));
    o_imms.b = XLEN_DEFAULT'(signed'(imm_b));
    o_imms.j = XLEN_DEFAULT'(signed'(imm_j));
    o_imms.z = XLEN_DEFAULT'(imm_z);
  end

endmodule

//--- rv_ctrl_gen.sv
// control generator, maps the matched kind to control and registers the result
`timescale 1ns/100ps

module rv_ctrl_gen
  import rv_decode_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_valid,
  input  logic [INST_W-1:0] i_inst,
  input  match_t            i_match,
  input  imm_set_t          i_imms,
  output logic              o_valid,
  output fields_t           o_fields,
  output logic [XLEN-1:0]   o_imm,
  output ctrl_t             o_ctrl,
  output exc_t              o_exc
);

  inst_e           kind;
  fields_t         fields_d;
  logic [XLEN-1:0] imm_d;
  ctrl_t           ctrl_d;
  exc_t            exc_d;
  logic            is_load;
  logic            is_store;

  assign kind = i_match.kind;

  assign fields_d.rs1 = i_inst[19:15];
  assign fields_d.rs2 = i_inst[24:20];
  assign fields_d.rd  = i_inst[11:7];
  assign fields_d.csr = i_inst[31:20];

  always_comb begin
    case (i_match.fmt)
      FMT_I:   imm_d = i_imms.i[XLEN-1:0];
      FMT_U:   imm_d = i_imms.u[XLEN-1:0];
      FMT_S:   imm_d = i_imms.s[XLEN-1:0];
      FMT_B:   imm_d = i_imms.b[XLEN-1:0];
      FMT_J:   imm_d = i_imms.j[XLEN-1:0];
      default: imm_d = '0;
    endcase
    if (kind == INST_CSRRWI) imm_d = i_imms.z[XLEN-1:0];
  end

  assign is_load  = kind inside {INST_LB, INST_LH, INST_LW, INST_LD,
                                 INST_LBU, INST_LHU, INST_LWU};
  assign is_store = i_match.fmt == FMT_S;

  always_comb begin
    ctrl_d = '0;

    ctrl_d.br_en = (i_match.fmt == FMT_B) || (kind inside {INST_JAL, INST_JALR});
    case (kind)
      INST_JALR: ctrl_d.br_func = BR_JALR;
      INST_BEQ:  ctrl_d.br_func = BR_BEQ;
      INST_BNE:  ctrl_d.br_func = BR_BNE;
      INST_BLT:  ctrl_d.br_func = BR_BLT;
      INST_BGE:  ctrl_d.br_func = BR_BGE;
      INST_BLTU: ctrl_d.br_func = BR_BLTU;
      INST_BGEU: ctrl_d.br_func = BR_BGEU;
      default:   ctrl_d.br_func = BR_JAL;
    endcase

    // operand a is the pc for pc-relative kinds
    ctrl_d.alu_src1_pc = kind inside {INST_AUIPC, INST_JAL, INST_JALR};
    if (kind inside {INST_JAL, INST_JALR})
      ctrl_d.alu_src2_sel = SRC2_FOUR;
    else if (i_match.fmt inside {FMT_I, FMT_U, FMT_S})
      ctrl_d.alu_src2_sel = SRC2_IMM;
    else
      ctrl_d.alu_src2_sel = SRC2_RS2;

    case (kind)
      INST_LUI:                                     ctrl_d.alu_op = ALU_COPYIMM;
      INST_AUIPC, INST_JAL, INST_JALR, INST_ADDI,
      INST_ADD, INST_ADDIW, INST_ADDW:              ctrl_d.alu_op = ALU_ADD;
      INST_SUB, INST_SUBW:                          ctrl_d.alu_op = ALU_SUB;
      INST_SLT, INST_SLTI:                          ctrl_d.alu_op = ALU_SLT;
      INST_SLTU, INST_SLTIU:                        ctrl_d.alu_op = ALU_SLTU;
      INST_XOR, INST_XORI:                          ctrl_d.alu_op = ALU_XOR;
      INST_AND, INST_ANDI:                          ctrl_d.alu_op = ALU_AND;
      INST_OR, INST_ORI:                            ctrl_d.alu_op = ALU_OR;
      INST_SLL, INST_SLLI, INST_SLLIW, INST_SLLW:   ctrl_d.alu_op = ALU_SLL;
      INST_SRL, INST_SRLI, INST_SRLIW, INST_SRLW:   ctrl_d.alu_op = ALU_SRL;
      INST_SRA, INST_SRAI, INST_SRAIW, INST_SRAW:   ctrl_d.alu_op = ALU_SRA;
      default: ctrl_d.alu_op = (is_load || is_store) ? ALU_ADD : ALU_INVALID;
    endcase

    ctrl_d.word_cut = kind inside {INST_ADDIW, INST_SLLIW, INST_SRLIW, INST_SRAIW,
                                   INST_ADDW, INST_SUBW, INST_SLLW, INST_SRLW,
                                   INST_SRAW};
    ctrl_d.gpr_wen  = i_match.fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
    ctrl_d.mem_ren  = is_load;
    ctrl_d.mem_wen  = is_store;

    // stores share the signed codes
    case (kind)
      INST_LB, INST_SB:  ctrl_d.mem_op = MEM_SB;
      INST_LBU:          ctrl_d.mem_op = MEM_UB;
      INST_LH, INST_SH:  ctrl_d.mem_op = MEM_SH;
      INST_LHU:          ctrl_d.mem_op = MEM_UH;
      INST_LW, INST_SW:  ctrl_d.mem_op = MEM_SW;
      INST_LWU:          ctrl_d.mem_op = MEM_UW;
      INST_LD, INST_SD:  ctrl_d.mem_op = MEM_D;
      default:           ctrl_d.mem_op = MEM_NONE;
    endcase

    ctrl_d.csr_inst = kind inside {INST_CSRRW, INST_CSRRS, INST_CSRRWI};
    // csrrw with rd zero skips the read, csrrs with rs1 zero skips the write
    ctrl_d.csr_ren  = ctrl_d.csr_inst && !(kind == INST_CSRRW && fields_d.rd == '0);
    ctrl_d.csr_wen  = ctrl_d.csr_inst && !(kind == INST_CSRRS && fields_d.rs1 == '0);
    ctrl_d.csr_op   = i_inst[14:12];
  end

  assign exc_d.ecall   = kind == INST_ECALL;
  assign exc_d.ebreak  = kind == INST_EBREAK;
  assign exc_d.mret    = kind == INST_MRET;
  assign exc_d.invalid = (i_match.fmt == FMT_NONE) && (i_inst != '0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_valid <= 1'b0;
      o_ctrl  <= '0;
      o_exc   <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_ctrl <= ctrl_d;
        o_exc  <= exc_d;
      end
    end
  end

  // payload, held between strobes
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_fields <= fields_d;
      o_imm    <= imm_d;
    end
  end

endmodule

//--- rv_idu.sv
// rv64i decode unit top, matcher and immediate generator feed the control stage
`timescale 1ns/100ps

module rv_idu
  import rv_decode_pkg::*;
#(
  parameter int XLEN = XLEN_DEFAULT
) (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic              i_valid,
  input  logic [INST_W-1:0] i_inst,
  output logic              o_valid,
  output fields_t           o_fields,
  output logic [XLEN-1:0]   o_imm,
  output ctrl_t             o_ctrl,
  output exc_t              o_exc
);

  match_t   match;
  imm_set_t imms;

  rv_inst_match i_rv_inst_match (
    .i_inst  (i_inst),
    .o_match (match)
  );

  rv_imm_gen #(
    .XLEN (XLEN)
  ) i_rv_imm_gen (
    .i_inst (i_inst),
    .o_imms (imms)
  );

  // single register stage
  rv_ctrl_gen #(
    .XLEN (XLEN)
  ) i_rv_ctrl_gen (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_valid  (i_valid),
    .i_inst   (i_inst),
    .i_match  (match),
    .i_imms   (imms),
    .o_valid  (o_valid),
    .o_fields (o_fields),
    .o_imm    (o_imm),
    .o_ctrl   (o_ctrl),
    .o_exc    (o_exc)
  );

endmodule

//--- tb_rv_idu.sv
// testbench replaying the decode cases file against the rv64i decode unit
`timescale 1ns/100ps

module tb_rv_idu
  import rv_decode_pkg::*;
();

  localparam int    XLEN         = 64;
  localparam int    CLK_PERIOD   = 20;
  localparam int    RESET_CYCLES = 10;
  localparam int    MAX_CASES    = 128;
  localparam string CASES_FILE   = "decode_cases.txt";

  typedef struct packed {
    logic [31:0]       cycle;  // cycle count at the strobe
    logic [INST_W-1:0] inst;
    fields_t           fields;
    logic [XLEN-1:0]   imm;
    ctrl_t             ctrl;
    exc_t              exc;
  } expect_t;

  logic              clk = 1'b0;
  logic              reset;
  logic              valid;
  logic [INST_W-1:0] inst;
  logic              o_valid;
  fields_t           o_fields;
  logic [XLEN-1:0]   o_imm;
  ctrl_t             o_ctrl;
  exc_t              o_exc;

  expect_t     cases [MAX_CASES];
  expect_t     exp_q [$];
  int          num_cases    = 0;
  logic        cases_ready  = 1'b0;
  logic [31:0] cycle_cnt    = '0;
  int          seed         = 42880;

  // outputs hold the last result while o_valid is low
  logic              have_last = 1'b0;
  logic [INST_W-1:0] last_inst;
  fields_t           last_fields;
  logic [XLEN-1:0]   last_imm;
  ctrl_t             last_ctrl;
  exc_t              last_exc;

  rv_idu #(
    .XLEN (XLEN)
  ) i_rv_idu (
    .i_clk    (clk),
    .i_reset  (reset),
    .i_valid  (valid),
    .i_inst   (inst),
    .o_valid  (o_valid),
    .o_fields (o_fields),
    .o_imm    (o_imm),
    .o_ctrl   (o_ctrl),
    .o_exc    (o_exc)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  task automatic stop_on_error();
    $display("SOME TESTS FAILED");
    $fatal(1, "decode check stopped the run");
  endtask

  task automatic check_fields(input fields_t got, input fields_t exp,
                              input logic [INST_W-1:0] word);
    if (got !== exp) begin
      $display("mismatch o_fields: got %h, expected %h, inst %h", got, exp, word);
      stop_on_error();
    end
  endtask

  task automatic check_imm(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                           input logic [INST_W-1:0] word);
    if (got !== exp) begin
      $display("mismatch o_imm: got %h, expected %h, inst %h", got, exp, word);
      stop_on_error();
    end
  endtask

  task automatic check_ctrl(input ctrl_t got, input ctrl_t exp,
                            input logic [INST_W-1:0] word);
    if (got !== exp) begin
      $display("mismatch o_ctrl: got %h, expected %h, inst %h", got, exp, word);
      stop_on_error();
    end
  endtask

  task automatic check_exc(input exc_t got, input exc_t exp,
                           input logic [INST_W-1:0] word);
    if (got !== exp) begin
      $display("mismatch o_exc: got %h, expected %h, inst %h", got, exp, word);
      stop_on_error();
    end
  endtask

  // one case per line with # lines skipped
  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] w;
    logic [31:0] f;
    logic [63:0] imm;
    logic [31:0] c;
    logic [31:0] e;
    expect_t     ce;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s", CASES_FILE);
      stop_on_error();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h", w, f, imm, c, e);
          if (n == 5 && num_cases < MAX_CASES) begin
            ce        = '0;
            ce.inst   = w;
            ce.fields = f[26:0];
            ce.imm    = imm;
            ce.ctrl   = c[24:0];
            ce.exc    = e[3:0];
            cases[num_cases] = ce;
            num_cases++;
          end else if (n > 0) begin
            $display("bad or surplus line in cases file: %s", line);
            stop_on_error();
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin : stimulus
    int      i;
    int      gap;
    expect_t exp;
    reset = 1'b1;
    valid = 1'b0;
    inst  = '0;
    load_cases();
    if (num_cases == 0) begin
      $display("no cases found in %s", CASES_FILE);
      stop_on_error();
    end
    cases_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);  // idle cycles with no result expected

    for (i = 0; i < num_cases; i++) begin
      @(negedge clk);
      valid     = 1'b1;
      inst      = cases[i].inst;
      exp       = cases[i];
      exp.cycle = cycle_cnt;
      exp_q.push_back(exp);
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(negedge clk);
        valid = 1'b0;
        inst  = $random(seed);  // junk on idle cycles
      end
    end
    @(negedge clk);
    valid = 1'b0;
    inst  = '0;

    while (exp_q.size() != 0) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("ALL TESTS PASSED");
    $finish;
  end

  // outputs are registered, so they are stable at the falling edge
  always @(negedge clk) begin : monitor
    expect_t exp;
    if (reset === 1'b0) begin
      if (o_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("o_valid went high with no strobe outstanding");
          stop_on_error();
        end else begin
          exp = exp_q.pop_front();
          if (cycle_cnt != exp.cycle + 1) begin
            $display("result for inst %h came %0d cycles after its strobe",
                     exp.inst, cycle_cnt - exp.cycle);
            stop_on_error();
          end
          check_fields(o_fields, exp.fields, exp.inst);
          check_imm(o_imm, exp.imm, exp.inst);
          check_ctrl(o_ctrl, exp.ctrl, exp.inst);
          check_exc(o_exc, exp.exc, exp.inst);
          have_last   = 1'b1;
          last_inst   = exp.inst;
          last_fields = exp.fields;
          last_imm    = exp.imm;
          last_ctrl   = exp.ctrl;
          last_exc    = exp.exc;
        end
      end else if (o_valid === 1'b0) begin
        if (exp_q.size() != 0) begin
          exp = exp_q[0];
          if (cycle_cnt > exp.cycle) begin
            $display("no result for inst %h one cycle after its strobe", exp.inst);
            stop_on_error();
          end
        end
        if (have_last) begin
          check_fields(o_fields, last_fields, last_inst);
          check_imm(o_imm, last_imm, last_inst);
          check_ctrl(o_ctrl, last_ctrl, last_inst);
          check_exc(o_exc, last_exc, last_inst);
        end else begin
          check_ctrl(o_ctrl, '0, '0);  // still in the reset state
          check_exc(o_exc, '0, '0);
        end
      end else begin
        $display("o_valid is unknown after reset");
        stop_on_error();
      end
    end
  end

  initial begin : watchdog
    longint limit;
    wait (cases_ready);
    limit = longint'(num_cases * 4 + 50) * CLK_PERIOD;
    #(limit);
    $display("timeout, the run did not finish within %0d clock periods",
             num_cases * 4 + 50);
    stop_on_error();
  end

endmodule

//--- decode_cases.txt
# inst fields(rs1 rs2 rd csr) imm ctrl exc, all hex
# ctrl packs br_en br_func src1_pc src2_sel alu_op word_cut gpr mren mwen mem_op csr bits
003100B3 0861003 0000000000000000 00009C0 0
403100B3 0861403 0000000000000000 00029C0 0
003120B3 0861003 0000000000000000 00049C2 0
003130B3 0861003 0000000000000000 00069C3 0
403150B3 0861403 0000000000000000 00129C5 0
FFF10093 0BE1FFF FFFFFFFFFFFFFFFF 00409C0 0
7FF13093 0BE17FF 00000000000007FF 00469C3 0
80014093 0801800 FFFFFFFFFFFFF800 00489C4 0
12317093 0861123 0000000000000123 004A9C7 0
02111093 0821021 0000000000000021 004E9C1 0
43F15093 0BE143F 000000000000043F 00529C5 0
FFE1009B 0BC1FFE FFFFFFFFFFFFFFFE 00419C0 0
41F1509B 0BE141F 000000000000041F 00539C5 0
003100BB 0861003 0000000000000000 00019C0 0
403100BB 0861403 0000000000000000 00039C0 0
800002B7 0005800 FFFFFFFF80000000 005E9C0 0
12345297 2065123 0000000012345000 01409C5 0
FFDFF06F 7FA0FFD FFFFFFFFFFFFFFFC 11809C7 0
008100E7 0901008 0000000000000008 13809C0 0
00310863 0870003 0000000000000010 143E1C0 0
FE311CE3 0879FE3 FFFFFFFFFFFFFFF8 163E1C1 0
00316863 0870003 0000000000000010 1C3E1C6 0
00317863 0870003 0000000000000010 1E3E1C7 0
00410083 0881004 0000000000000004 0040C00 0
00411083 0881004 0000000000000004 0040C81 0
FF813083 0B01FF8 FFFFFFFFFFFFFFF8 0040D83 0
00414083 0881004 0000000000000004 0040C44 0
00416083 0881004 0000000000000004 0040D46 0
003102A3 0865003 0000000000000005 0040200 0
003122A3 0865003 0000000000000005 0040302 0
FE313823 0870FE3 FFFFFFFFFFFFFFF0 0040383 0
300110F3 0801300 0000000000000300 007E9F9 0
30511073 08A0305 0000000000000305 007E9E9 0
342020F3 0041342 0000000000000342 007E9F2 0
342120F3 0841342 0000000000000342 007E9FA 0
300FD0F3 7C01300 000000000000001F 007E9FD 0
00000073 0000000 0000000000000000 007E9C0 8
00100073 0020001 0000000000000001 007E9C0 4
30200073 0040302 0000000000000000 003E9C0 2
023100B3 0861023 0000000000000000 003E1C0 1
023140B3 0861023 0000000000000000 003E1C4 1
023100BB 0861023 0000000000000000 003E1C0 1
FFFFFFFF 7FFFFFF 0000000000000000 003E1C7 1
00000000 0000000 0000000000000000 003E1C0 0

//--- src.f
rv_decode_pkg.sv
rv_inst_match.sv
rv_imm_gen.sv
rv_ctrl_gen.sv
rv_idu.sv
tb_rv_idu.sv

//--- Bender.yml
package:
  name: rv_idu

sources:
  - rv_decode_pkg.sv
  - rv_inst_match.sv
  - rv_imm_gen.sv
  - rv_ctrl_gen.sv
  - rv_idu.sv
  - target: test
    files:
      - tb_rv_idu.sv
